// File: verilog/oled_pkg.sv
package oled_pkg;

    //////////////////////////////
    // Serial word
    //////////////////////////////
    localparam int BYTE_W = 8;                      // One panel byte

    //////////////////////////////
    // Power-up command table
    //////////////////////////////
    localparam int INIT_LEN = 12;

    // Sent with dc low, first entry first
    localparam logic [BYTE_W-1:0] INIT_ROM [INIT_LEN] = '{
        8'hAE,                                      // Display off
        8'hD5,                                      // Clock divide / osc freq
        8'h80,                                      //   Reset value
        8'hA8,                                      // Multiplex ratio
        8'h3F,                                      //   64 rows
        8'h8D,                                      // Charge pump
        8'h14,                                      //   Enabled
        8'h20,                                      // Memory addressing mode
        8'h00,                                      //   Horizontal
        8'hA1,                                      // Segment remap, col 127 = SEG0
        8'hC8,                                      // COM scan reverse
        8'hAF                                       // Display on
    };

    //////////////////////////////
    // Default timing
    //////////////////////////////
    localparam int DEF_CLK_DIV    = 5;              // Sys clocks per half sclk period
    localparam int DEF_RES_CYCLES = 64;             // Panel reset pulse length
    localparam int DEF_FIFO_DEPTH = 8;              // Power of two

endpackage

// File: verilog/oled_cmd_fifo.sv
`timescale 1ns/1ps

module oled_cmd_fifo #(
    parameter int FIFO_DEPTH = 8                    // Power of two, 2 or more
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // Host write side
    input  logic                        wr_valid,   // Single-cycle strobe
    input  logic                        wr_dc,      // 1 data, 0 command
    input  logic [oled_pkg::BYTE_W-1:0] wr_byte,
    // Sequencer read side
    input  logic                        q_pop,
    output logic                        q_dc,
    output logic [oled_pkg::BYTE_W-1:0] q_byte,
    output logic                        q_empty,
    // Status
    output logic                        fifo_full,
    output logic                        overflow    // Sticky until reset
);

    localparam int AW = $clog2(FIFO_DEPTH);

    // Extra MSB tells full from empty
    logic [AW:0]                 wr_ptr;
    logic [AW:0]                 rd_ptr;
    logic [oled_pkg::BYTE_W-1:0] mem_byte [FIFO_DEPTH];
    logic                        mem_dc   [FIFO_DEPTH];
    logic                        wr_en;
    logic                        rd_en;

    //////////////////////////////
    // Flags from the pointer flops
    //////////////////////////////
    assign q_empty   = (wr_ptr == rd_ptr);
    assign fifo_full = (wr_ptr[AW] != rd_ptr[AW]) &&
                       (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]); // Wrapped once, same slot

    assign wr_en = wr_valid && !fifo_full;          // Dropped when full
    assign rd_en = q_pop && !q_empty;

    // Head entry always on the outputs
    assign q_byte = mem_byte[rd_ptr[AW-1:0]];
    assign q_dc   = mem_dc[rd_ptr[AW-1:0]];

    //////////////////////////////
    // Storage
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_byte[wr_ptr[AW-1:0]] <= wr_byte;
            mem_dc[wr_ptr[AW-1:0]]   <= wr_dc;
        end
    end

    // Pointers and overflow latch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;            // Both may move in one cycle
            end
            if (wr_valid && fifo_full) begin
                overflow <= 1'b1;                   // Lost a host byte
            end
        end
    end

endmodule

// File: verilog/oled_init_seq.sv
`timescale 1ns/1ps

module oled_init_seq #(
    parameter int RES_CYCLES = 64                   // Panel reset pulse, sys clocks
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // Panel control
    output logic                        oled_res_n,
    output logic                        init_done,
    // Queue head
    input  logic                        q_dc,
    input  logic [oled_pkg::BYTE_W-1:0] q_byte,
    input  logic                        q_empty,
    output logic                        q_pop,
    // Shifter handshake
    output logic                        start,
    output logic                        tx_dc,
    output logic [oled_pkg::BYTE_W-1:0] tx_byte,
    input  logic                        tx_busy,
    input  logic                        tx_done
);

    localparam int RC_W = $clog2(RES_CYCLES + 1);
    localparam int IW   = $clog2(oled_pkg::INIT_LEN);

    localparam logic [RC_W-1:0] RES_LAST = RC_W'(RES_CYCLES - 1);
    localparam logic [IW-1:0]   TBL_LAST = IW'(oled_pkg::INIT_LEN - 1);

    // State encodings
    localparam logic [2:0] ST_RES       = 3'd0;     // Panel held in reset
    localparam logic [2:0] ST_SETTLE    = 3'd1;     // One idle clock
    localparam logic [2:0] ST_TBL_ISSUE = 3'd2;
    localparam logic [2:0] ST_TBL_WAIT  = 3'd3;
    localparam logic [2:0] ST_Q_ISSUE   = 3'd4;
    localparam logic [2:0] ST_Q_WAIT    = 3'd5;

    logic [2:0]      state;
    logic [RC_W-1:0] res_cnt;
    logic [IW-1:0]   tbl_idx;                       // Next INIT_ROM entry
    logic            tbl_go;
    logic            q_go;

    //////////////////////////////
    // Issue decode
    //////////////////////////////
    assign tbl_go = (state == ST_TBL_ISSUE) && !tx_busy;
    assign q_go   = (state == ST_Q_ISSUE) && !q_empty && !tx_busy;

    assign start = tbl_go || q_go;
    assign q_pop = q_go;                            // Pop together with start

    // Table bytes are always commands
    assign tx_dc   = (state == ST_Q_ISSUE) ? q_dc : 1'b0;
    assign tx_byte = (state == ST_Q_ISSUE) ? q_byte : oled_pkg::INIT_ROM[tbl_idx];

    //////////////////////////////
    // Sequencer FSM
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_RES;
            res_cnt    <= '0;
            tbl_idx    <= '0;
            oled_res_n <= 1'b0;                     // Pulse starts with system reset
            init_done  <= 1'b0;
        end else begin
            case (state)
                ST_RES: begin
                    if (res_cnt == RES_LAST) begin
                        oled_res_n <= 1'b1;         // Release the panel
                        state      <= ST_SETTLE;
                    end else begin
                        res_cnt <= res_cnt + 1'b1;
                    end
                end

                ST_SETTLE: begin
                    state <= ST_TBL_ISSUE;
                end

                ST_TBL_ISSUE: begin
                    if (tbl_go) begin
                        state <= ST_TBL_WAIT;
                    end
                end

                ST_TBL_WAIT: begin
                    if (tx_done) begin
                        if (tbl_idx == TBL_LAST) begin
                            init_done <= 1'b1;      // Panel is up, host bytes next
                            state     <= ST_Q_ISSUE;
                        end else begin
                            tbl_idx <= tbl_idx + 1'b1;
                            state   <= ST_TBL_ISSUE;
                        end
                    end
                end

                ST_Q_ISSUE: begin
                    if (q_go) begin
                        state <= ST_Q_WAIT;
                    end
                end

                ST_Q_WAIT: begin
                    if (tx_done) begin
                        state <= ST_Q_ISSUE;
                    end
                end

                default: begin
                    state <= ST_RES;
                end
            endcase
        end
    end

endmodule

// File: verilog/oled_spi_byte_tx.sv
`timescale 1ns/1ps

module oled_spi_byte_tx #(
    parameter int CLK_DIV = 5                       // Sys clocks per step
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // Handshake
    input  logic                        start,      // One cycle, only when idle
    input  logic                        tx_dc,
    input  logic [oled_pkg::BYTE_W-1:0] tx_byte,
    output logic                        tx_busy,
    output logic                        tx_done,
    // Panel pins
    output logic                        oled_cs_n,
    output logic                        oled_sclk,
    output logic                        oled_dc,
    output logic                        oled_sdin
);

    localparam int DW = $clog2(CLK_DIV + 1);

    localparam logic [DW-1:0] DIV_LAST  = DW'(CLK_DIV - 1);
    localparam logic [4:0]    LAST_STEP = 5'd17;

    logic [DW-1:0]               div_cnt;
    logic [4:0]                  step;             // 0 cs low, 1..16 bits, 17 hold
    logic [4:0]                  step_nxt;
    logic                        step_end;
    logic [oled_pkg::BYTE_W-1:0] shreg;

    //////////////////////////////
    // Step timing
    //////////////////////////////
    assign step_end = tx_busy && (div_cnt == DIV_LAST); // Clock enable, frame only
    assign step_nxt = step + 1'b1;

    // Odd steps 1..15 put out the next bit
    always_ff @(posedge clk) begin
        if (start && !tx_busy) begin
            shreg <= tx_byte;
        end else if (step_end && step_nxt[0] && (step_nxt != LAST_STEP)) begin
            shreg <= shreg << 1;                    // MSB first
        end
    end

    //////////////////////////////
    // Frame control and pins
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy   <= 1'b0;
            tx_done   <= 1'b0;
            div_cnt   <= '0;
            step      <= '0;
            oled_cs_n <= 1'b1;
            oled_sclk <= 1'b0;
            oled_dc   <= 1'b0;
            oled_sdin <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (!tx_busy) begin
                if (start) begin
                    tx_busy   <= 1'b1;
                    oled_dc   <= tx_dc;             // Held until next start
                    oled_cs_n <= 1'b0;              // Step 0, sclk already low
                    div_cnt   <= '0;
                    step      <= '0;
                end
            end else if (step_end) begin
                div_cnt <= '0;
                if (step == LAST_STEP) begin
                    // End of frame, no trailing idle step
                    tx_busy   <= 1'b0;
                    tx_done   <= 1'b1;
                    oled_cs_n <= 1'b1;
                end else begin
                    step <= step_nxt;
                    if (step_nxt[0]) begin
                        oled_sclk <= 1'b0;          // Low phase, incl. step 17
                        if (step_nxt != LAST_STEP) begin
                            oled_sdin <= shreg[oled_pkg::BYTE_W-1];
                        end
                    end else begin
                        oled_sclk <= 1'b1;          // Panel samples on this edge
                    end
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

// File: verilog/oled_spi_ctrl.sv
`timescale 1ns/1ps

module oled_spi_ctrl #(
    parameter int CLK_DIV    = oled_pkg::DEF_CLK_DIV,
    parameter int RES_CYCLES = oled_pkg::DEF_RES_CYCLES,
    parameter int FIFO_DEPTH = oled_pkg::DEF_FIFO_DEPTH
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // Host side
    input  logic                        wr_valid,
    input  logic                        wr_dc,
    input  logic [oled_pkg::BYTE_W-1:0] wr_byte,
    output logic                        fifo_full,
    output logic                        overflow,
    output logic                        busy,
    output logic                        init_done,
    // Panel pins
    output logic                        oled_res_n,
    output logic                        oled_cs_n,
    output logic                        oled_sclk,
    output logic                        oled_dc,
    output logic                        oled_sdin
);

    // Queue to sequencer
    logic                        q_dc;
    logic [oled_pkg::BYTE_W-1:0] q_byte;
    logic                        q_empty;
    logic                        q_pop;

    // Sequencer to shifter
    logic                        start;
    logic                        tx_dc;
    logic [oled_pkg::BYTE_W-1:0] tx_byte;
    logic                        tx_busy;
    logic                        tx_done;

    assign busy = !q_empty || tx_busy;              // Work pending or on the wire

    //////////////////////////////
    // Blocks
    //////////////////////////////
    oled_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_valid  (wr_valid),
        .wr_dc     (wr_dc),
        .wr_byte   (wr_byte),
        .q_pop     (q_pop),
        .q_dc      (q_dc),
        .q_byte    (q_byte),
        .q_empty   (q_empty),
        .fifo_full (fifo_full),
        .overflow  (overflow)
    );

    oled_init_seq #(
        .RES_CYCLES (RES_CYCLES)
    ) i_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .oled_res_n (oled_res_n),
        .init_done  (init_done),
        .q_dc       (q_dc),
        .q_byte     (q_byte),
        .q_empty    (q_empty),
        .q_pop      (q_pop),
        .start      (start),
        .tx_dc      (tx_dc),
        .tx_byte    (tx_byte),
        .tx_busy    (tx_busy),
        .tx_done    (tx_done)
    );

    oled_spi_byte_tx #(
        .CLK_DIV (CLK_DIV)
    ) i_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .tx_dc     (tx_dc),
        .tx_byte   (tx_byte),
        .tx_busy   (tx_busy),
        .tx_done   (tx_done),
        .oled_cs_n (oled_cs_n),
        .oled_sclk (oled_sclk),
        .oled_dc   (oled_dc),
        .oled_sdin (oled_sdin)
    );

endmodule

// File: sim/oled_spi_ctrl_tb.sv
`timescale 1ns/1ps

module oled_spi_ctrl_tb;

    localparam int CLK_DIV    = 2;
    localparam int RES_CYCLES = 16;
    localparam int FIFO_DEPTH = 4;
    localparam int BW         = oled_pkg::BYTE_W;
    localparam int INIT_LEN   = oled_pkg::INIT_LEN;
    localparam int N_HOST     = 12;                 // Ordered writes that wait for room
    localparam int N_OVF      = 10;                 // Burst writes into a full queue
    // Reset plus panel pulse plus 40 * CLK_DIV per byte plus margin
    localparam int MAX_CYCLES = 16 + RES_CYCLES +
                                40 * CLK_DIV * (INIT_LEN + N_HOST + N_OVF) + 400;

    logic          clk;
    logic          rst_n;
    logic          wr_valid;
    logic          wr_dc;
    logic [BW-1:0] wr_byte;
    logic          fifo_full;
    logic          overflow;
    logic          busy;
    logic          init_done;
    logic          oled_res_n;
    logic          oled_cs_n;
    logic          oled_sclk;
    logic          oled_dc;
    logic          oled_sdin;

    logic [BW:0]   host_q [$];                      // Accepted writes as {dc, byte}
    logic [BW:0]   rx_q   [$];                      // Frames seen on the pins
    logic [BW:0]   rx_word;
    logic [BW:0]   exp_word;
    logic [BW-1:0] rx_shift;
    logic          frame_dc;
    logic          in_frame    = 1'b0;
    logic          dc_bad      = 1'b0;
    logic          ovf_armed   = 1'b0;              // Set once a write was dropped
    int            edge_cnt    = 0;
    int            frame_cnt   = 0;
    int            host_starts = 0;                 // Host frames begun, one pop each
    int            cmp_idx     = 0;
    int            bad_frames  = 0;
    int            cs_in_reset = 0;
    int            dropped     = 0;
    int            cycles      = 0;
    int            errors      = 0;
    int            checks      = 0;
    int            tests_run   = 0;
    int            tests_fail  = 0;

    oled_spi_ctrl #(
        .CLK_DIV    (CLK_DIV),
        .RES_CYCLES (RES_CYCLES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_valid   (wr_valid),
        .wr_dc      (wr_dc),
        .wr_byte    (wr_byte),
        .fifo_full  (fifo_full),
        .overflow   (overflow),
        .busy       (busy),
        .init_done  (init_done),
        .oled_res_n (oled_res_n),
        .oled_cs_n  (oled_cs_n),
        .oled_sclk  (oled_sclk),
        .oled_dc    (oled_dc),
        .oled_sdin  (oled_sdin)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;                           // 4 ns period

    //////////////////////////////
    // Helpers
    //////////////////////////////
    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // Table first, then host writes in acceptance order
    function automatic logic [BW:0] expected_byte(input int idx);
        if (idx < INIT_LEN) begin
            return {1'b0, oled_pkg::INIT_ROM[idx]};
        end
        return host_q[idx - INIT_LEN];
    endfunction

    task automatic report_test(input int num, input string name, input int fails);
        tests_run++;
        if (fails == 0) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_fail++;
            $display("test %0d %s: FAIL, %0d errors", num, name, fails);
        end
    endtask

    // One strobe with acceptance read at the following negedge
    task automatic host_write(input logic dc, input logic [BW-1:0] b,
                              input bit wait_room, output bit taken);
        if (wait_room) begin
            @(negedge clk);
            while (fifo_full) @(negedge clk);       // Only pops can follow
        end
        @(posedge clk);
        wr_valid <= 1'b1;
        wr_dc    <= dc;
        wr_byte  <= b;
        @(negedge clk);
        // Entries held equal accepted writes less host frames begun
        check_val("fifo_full", 32'(fifo_full),
                  32'((host_q.size() - host_starts) == FIFO_DEPTH));
        taken = !fifo_full;                         // Value the DUT samples next edge
        if (taken) begin
            host_q.push_back({dc, b});
        end else begin
            dropped++;
        end
        @(posedge clk);
        wr_valid <= 1'b0;
        if (!taken) ovf_armed = 1'b1;
    endtask

    //////////////////////////////
    // Serial-bus monitor
    //////////////////////////////
    always @(negedge oled_cs_n) begin
        if (rst_n) begin
            in_frame = 1'b1;
            edge_cnt = 0;
            dc_bad   = 1'b0;
            rx_shift = '0;
            if (init_done) host_starts++;           // Head entry popped this edge
            if (!oled_res_n) begin
                errors++;
                $display("Chip select fell while the panel was held in reset");
            end
            check_val("oled_sclk at cs_n fall", 32'(oled_sclk), 32'h0);
        end
    end

    always @(posedge oled_sclk) begin
        if (in_frame) begin
            if (edge_cnt == 0) frame_dc = oled_dc;  // dc settles with cs_n
            else if (oled_dc !== frame_dc) dc_bad = 1'b1;
            rx_shift = {rx_shift[BW-2:0], oled_sdin}; // MSB arrives first
            edge_cnt++;
        end
    end

    always @(posedge oled_cs_n) begin
        if (in_frame) begin
            in_frame = 1'b0;
            if (oled_dc !== frame_dc) dc_bad = 1'b1;
            check_val("oled_sclk edges", edge_cnt, 8);
            check_val("oled_sclk at cs_n rise", 32'(oled_sclk), 32'h0);
            check_val("oled_dc stable", 32'(dc_bad), 32'h0);
            if (edge_cnt != 8 || oled_sclk !== 1'b0 || dc_bad) bad_frames++;
            rx_q.push_back({frame_dc, rx_shift});
            frame_cnt++;
        end
    end

    // Compare against the reference stream
    always @(posedge clk) begin
        while (rx_q.size() > 0) begin
            rx_word = rx_q.pop_front();
            if (cmp_idx >= INIT_LEN + host_q.size()) begin
                errors++;
                $display("Frame %0d has no matching table entry or host write", cmp_idx);
            end else begin
                exp_word = expected_byte(cmp_idx);
                check_val("oled_dc", 32'(rx_word[BW]), 32'(exp_word[BW]));
                check_val("oled_sdin", 32'(rx_word[BW-1:0]), 32'(exp_word[BW-1:0]));
            end
            cmp_idx++;
        end
    end

    // Pin rules checked every cycle
    always @(negedge clk) begin
        if (rst_n && !oled_res_n && oled_cs_n !== 1'b1) cs_in_reset++;
        if (ovf_armed) check_val("overflow", 32'(overflow), 32'h1); // Sticky
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, run stopped after %0d cycles with %0d frames seen",
                     cycles, frame_cnt);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        int err_mark;
        int res_low;
        bit taken;
        void'($urandom(32'h2d79));
        rst_n    = 1'b0;
        wr_valid = 1'b0;
        wr_dc    = 1'b0;
        wr_byte  = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // 1 panel reset pulse
        err_mark = errors;
        res_low  = 0;
        @(negedge clk);
        check_val("oled_res_n", 32'(oled_res_n), 32'h0);
        while (!oled_res_n) begin
            res_low++;
            @(negedge clk);
        end
        check_val("oled_res_n low cycles", res_low, RES_CYCLES);
        check_val("frames before panel release", frame_cnt, 0);
        check_val("cs_n low in panel reset", cs_in_reset, 0);
        report_test(1, "panel reset", errors - err_mark);

        // 2 power-up table
        err_mark = errors;
        while (!init_done) @(negedge clk);
        check_val("init frames", frame_cnt, INIT_LEN);
        repeat (2) @(posedge clk);                  // Compare drains
        check_val("init frames compared", cmp_idx, INIT_LEN);
        report_test(2, "init sequence", errors - err_mark);

        // 4 host bytes in order
        err_mark = errors;
        for (int i = 0; i < N_HOST; i++) begin
            host_write(1'($urandom()), BW'($urandom()), 1'b1, taken);
            check_val("write accepted", 32'(taken), 32'h1);
            repeat ($urandom_range(3)) @(posedge clk);
        end
        check_val("overflow", 32'(overflow), 32'h0);
        report_test(4, "host ordering", errors - err_mark);

        // 5 burst into a full queue
        err_mark = errors;
        for (int i = 0; i < N_OVF; i++) begin
            host_write(1'($urandom()), BW'($urandom()), 1'b0, taken);
        end
        check_val("some writes dropped", 32'(dropped > 0), 32'h1);
        @(negedge clk);
        check_val("overflow", 32'(overflow), 32'h1);
        report_test(5, "overflow", errors - err_mark);

        // 6 drain
        err_mark = errors;
        @(negedge clk);
        while (busy) @(negedge clk);
        repeat (3) @(posedge clk);
        check_val("frame count", frame_cnt, INIT_LEN + host_q.size());
        check_val("frames compared", cmp_idx, frame_cnt);
        check_val("init_done", 32'(init_done), 32'h1);
        report_test(6, "drain", errors - err_mark);

        // 3 frame shape judged over every frame
        report_test(3, "frame shape", bad_frames);

        $display("tests %0d, failed %0d, checks %0d, errors %0d, frames %0d, dropped %0d",
                 tests_run, tests_fail, checks, errors, frame_cnt, dropped);
        if (errors == 0 && tests_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: oled_spi_ctrl.f
verilog/oled_pkg.sv
verilog/oled_cmd_fifo.sv
verilog/oled_init_seq.sv
verilog/oled_spi_byte_tx.sv
verilog/oled_spi_ctrl.sv
sim/oled_spi_ctrl_tb.sv

// File: Makefile
# Verilator flow for the OLED serial controller

VERILATOR  ?= verilator
FILELIST   ?= oled_spi_ctrl.f
TB_TOP     ?= oled_spi_ctrl_tb
RTL_TOP    ?= oled_spi_ctrl
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing
FAIL_MSG   ?= Test failed
PASS_MSG   ?= Test completed successfully

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
